//--- design/char_draw.sv
// character layer: tile map and pattern rams, their loading, two-stage scan lookup
module char_draw
    import line_video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    // table loading
    input  logic               prog_en,
    input  prog_target_e       prog_sel,
    input  logic [PROG_AW-1:0] prog_addr,
    input  logic [PROG_DW-1:0] prog_data,

    // scan
    input  logic               scan_en,
    input  logic [7:0]         hdump,
    input  logic [2:0]         char_row,   // row within the 8-pixel tile
    output logic [COLOR_W-1:0] char_color
);

    logic [7:0]         map_ram [32];   // {code[3:0], cpal[3:0]} per column
    logic [PROG_DW-1:0] pat_ram [128];  // {code, row} -> 8 pixels x 2 bits

    // stage 1 results
    logic [3:0]         s1_code;
    logic [3:0]         s1_cpal;
    logic [2:0]         s1_col;         // pixel column inside the tile

    // stage 2 lookup
    logic [PROG_DW-1:0] pat_row;
    logic [1:0]         pix_idx;

    // loading, one write per cycle
    always_ff @(posedge clk) begin
        if (prog_en && prog_sel == PROG_CHAR_MAP) begin
            map_ram[prog_addr[4:0]] <= prog_data[7:0];
        end
        if (prog_en && prog_sel == PROG_CHAR_PAT) begin
            pat_ram[prog_addr] <= prog_data;
        end
    end

    assign pat_row = pat_ram[{s1_code, char_row}];
    assign pix_idx = pat_row[2*s1_col +: 2];  // pixel p in bits 2p+1..2p

    // stage 1 map read, stage 2 pattern read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_code    <= '0;
            s1_cpal    <= '0;
            s1_col     <= '0;
            char_color <= '0;
        end else begin
            if (scan_en) begin
                {s1_code, s1_cpal} <= map_ram[hdump[7:3]];  // tile column
                s1_col             <= hdump[2:0];
            end
            // low two palette bits above the 2-bit index
            char_color <= {s1_cpal[1:0], pix_idx};
        end
    end

endmodule

//--- design/layer_mix.sv
// layer mixer: aligns object pixel to char pixel, opaque object wins
module layer_mix
    import line_video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               scan_en,
    input  logic               obj_opaque,   // from the buffer, one cycle after scan
    input  logic [COLOR_W-1:0] obj_color,
    input  logic [COLOR_W-1:0] char_color,   // two cycles after scan
    output logic               pix_valid,
    output logic [COLOR_W-1:0] pix_color
);

    logic [SCAN_LAT-1:0] vld;         // scan strobe delay line
    logic                obj_opq_d;   // alignment stage
    logic [COLOR_W-1:0]  obj_col_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld       <= '0;
            obj_opq_d <= 1'b0;
        end else begin
            vld       <= {vld[SCAN_LAT-2:0], scan_en};
            obj_opq_d <= obj_opaque;
        end
    end

    always_ff @(posedge clk) begin
        obj_col_d <= obj_color;
        pix_color <= obj_opq_d ? obj_col_d : char_color;  // object over char
    end

    assign pix_valid = vld[SCAN_LAT-1];  // scan strobe plus SCAN_LAT

endmodule

//--- design/line_video_pkg.sv
// shared sizes, programming target enum and object drawer state enum
package line_video_pkg;

    // scanline geometry
    localparam int LINE_W   = 256;  // pixels per line, 8-bit hdump
    localparam int OBJ_W    = 16;   // object width in pixels

    // object pattern rom
    localparam int ROM_AW   = 12;   // {code[7:0], row[3:0]}

    // video color out of every layer
    localparam int COLOR_W  = 4;

    // programming bus
    localparam int PROG_AW  = 7;    // widest target is the char pattern ram
    localparam int PROG_DW  = 16;   // one pattern row of 8 two-bit pixels

    // scan strobe to pixel out
    // buffer read, align, output register on the object side
    // map read, pattern read, output register on the char side
    localparam int SCAN_LAT = 3;

    // which table a programming write lands in
    typedef enum logic [1:0] {
        PROG_OBJ_PAL  = 2'd0,   // 64 x 4 object palette
        PROG_CHAR_MAP = 2'd1,   // 32 x 8 tile map
        PROG_CHAR_PAT = 2'd2    // 128 x 16 char patterns
    } prog_target_e;

    // object drawer FSM
    typedef enum logic [1:0] {
        OBJ_IDLE  = 2'd0,   // ready for a descriptor
        OBJ_FETCH = 2'd1,   // waiting on the rom
        OBJ_DRAW  = 2'd2    // one pixel per cycle into the buffer
    } obj_state_e;

endpackage

//--- design/line_video_top.sv
// top level: object drawer, line buffer, character layer and mixer
module line_video_top
    import line_video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    // object descriptors
    input  logic               obj_valid,
    output logic               obj_ready,
    input  logic [7:0]         obj_xpos,
    input  logic [3:0]         obj_row,
    input  logic [7:0]         obj_code,
    input  logic [3:0]         obj_pal,
    input  logic               obj_hflip,
    input  logic               obj_vflip,

    // object pattern rom
    output logic               rom_req,
    output logic [ROM_AW-1:0]  rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ack,

    // table programming
    input  logic               prog_en,
    input  prog_target_e       prog_sel,
    input  logic [PROG_AW-1:0] prog_addr,
    input  logic [PROG_DW-1:0] prog_data,

    // line timing and scan
    input  logic               line_start,
    input  logic               scan_en,
    input  logic [7:0]         hdump,
    input  logic [2:0]         char_row,

    // mixed pixel out
    output logic               pix_valid,
    output logic [COLOR_W-1:0] pix_color
);

    logic               buf_we;
    logic [7:0]         buf_waddr;
    logic [COLOR_W-1:0] buf_wdata;
    logic               obj_opaque;
    logic [COLOR_W-1:0] obj_color;
    logic [COLOR_W-1:0] char_color;

    obj_draw u_obj_draw (
        .clk       (clk),
        .rst       (rst),
        .obj_valid (obj_valid),
        .obj_ready (obj_ready),
        .obj_xpos  (obj_xpos),
        .obj_row   (obj_row),
        .obj_code  (obj_code),
        .obj_pal   (obj_pal),
        .obj_hflip (obj_hflip),
        .obj_vflip (obj_vflip),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ack   (rom_ack),
        .prog_en   (prog_en),
        .prog_sel  (prog_sel),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .buf_we    (buf_we),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata)
    );

    obj_line_buffer u_obj_line_buffer (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .buf_we     (buf_we),
        .buf_waddr  (buf_waddr),
        .buf_wdata  (buf_wdata),
        .scan_en    (scan_en),
        .hdump      (hdump),
        .obj_opaque (obj_opaque),
        .obj_color  (obj_color)
    );

    char_draw u_char_draw (
        .clk        (clk),
        .rst        (rst),
        .prog_en    (prog_en),
        .prog_sel   (prog_sel),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .scan_en    (scan_en),
        .hdump      (hdump),
        .char_row   (char_row),
        .char_color (char_color)
    );

    layer_mix u_layer_mix (
        .clk        (clk),
        .rst        (rst),
        .scan_en    (scan_en),
        .obj_opaque (obj_opaque),
        .obj_color  (obj_color),
        .char_color (char_color),
        .pix_valid  (pix_valid),
        .pix_color  (pix_color)
    );

endmodule

//--- design/obj_draw.sv
// object drawer: descriptor intake, pattern rom fetch, palette lookup, line buffer writes
module obj_draw
    import line_video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    // descriptor intake
    input  logic               obj_valid,
    output logic               obj_ready,
    input  logic [7:0]         obj_xpos,
    input  logic [3:0]         obj_row,
    input  logic [7:0]         obj_code,
    input  logic [3:0]         obj_pal,
    input  logic               obj_hflip,
    input  logic               obj_vflip,

    // pattern rom, variable latency
    output logic               rom_req,
    output logic [ROM_AW-1:0]  rom_addr,
    input  logic [31:0]        rom_data,
    input  logic               rom_ack,

    // palette loading
    input  logic               prog_en,
    input  prog_target_e       prog_sel,
    input  logic [PROG_AW-1:0] prog_addr,
    input  logic [PROG_DW-1:0] prog_data,

    // line buffer write side
    output logic               buf_we,
    output logic [7:0]         buf_waddr,
    output logic [COLOR_W-1:0] buf_wdata
);

    obj_state_e         state;
    logic               accept;        // descriptor taken this cycle
    logic [3:0]         cnt;           // pixel counter in OBJ_DRAW
    logic [3:0]         cur_pal;
    logic               cur_hflip;
    logic [31:0]        pat;           // plane A in 15..0, plane B in 31..16
    logic [7:0]         waddr;         // buffer address of the current pixel
    logic [1:0]         pix_idx;
    logic [COLOR_W-1:0] pal_ram [64];  // {pal, index} -> color

    assign obj_ready = (state == OBJ_IDLE);
    assign accept    = obj_valid && obj_ready;

    // FSM and rom request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= OBJ_IDLE;
            rom_req <= 1'b0;
            cnt     <= '0;
        end else begin
            case (state)
                OBJ_IDLE: begin
                    if (accept) begin
                        state   <= OBJ_FETCH;
                        rom_req <= 1'b1;  // rises the cycle after acceptance
                    end
                end
                OBJ_FETCH: begin
                    if (rom_ack) begin
                        state   <= OBJ_DRAW;
                        rom_req <= 1'b0;  // drops right after the ack
                        cnt     <= '0;
                    end
                end
                OBJ_DRAW: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'(OBJ_W - 1)) begin
                        state <= OBJ_IDLE;  // 16 pixels out
                    end
                end
                default: state <= OBJ_IDLE;
            endcase
        end
    end

    // descriptor capture and pixel shifting
    always_ff @(posedge clk) begin
        if (accept) begin
            rom_addr  <= {obj_code, obj_row ^ {4{obj_vflip}}};  // vflip inverts the row
            cur_pal   <= obj_pal;
            cur_hflip <= obj_hflip;
            // hflip starts at the right edge and walks left
            waddr     <= obj_xpos + (obj_hflip ? 8'(OBJ_W - 1) : 8'd0);
        end
        if (state == OBJ_FETCH && rom_ack) begin
            pat <= rom_data;
        end
        if (state == OBJ_DRAW) begin
            pat   <= pat >> 1;  // next pixel into bits 16 and 0
            waddr <= cur_hflip ? waddr - 8'd1 : waddr + 8'd1;  // wraps at 255
        end
    end

    // palette ram, loaded through its own target
    always_ff @(posedge clk) begin
        if (prog_en && prog_sel == PROG_OBJ_PAL) begin
            pal_ram[prog_addr[5:0]] <= prog_data[COLOR_W-1:0];
        end
    end

    // plane B then plane A
    assign pix_idx = {pat[16], pat[0]};

    // index 0 is transparent and never written
    assign buf_we    = (state == OBJ_DRAW) && (pix_idx != 2'd0);
    assign buf_waddr = waddr;
    assign buf_wdata = pal_ram[{cur_pal, pix_idx}];  // combinational palette read

endmodule

//--- design/obj_line_buffer.sv
// double-buffered object line buffer with bank swap on line start and clear after read
module obj_line_buffer
    import line_video_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               line_start,  // swaps write and read banks

    // writes from the object drawer
    input  logic               buf_we,
    input  logic [7:0]         buf_waddr,
    input  logic [COLOR_W-1:0] buf_wdata,

    // scan side, read then clear
    input  logic               scan_en,
    input  logic [7:0]         hdump,
    output logic               obj_opaque,
    output logic [COLOR_W-1:0] obj_color
);

    logic                   wbank;    // bank being drawn into
    logic                   rbank;    // bank being scanned out
    logic [1:0][LINE_W-1:0] opq;      // opaque flag per pixel, per bank
    logic [COLOR_W-1:0]     col_ram [2][LINE_W];

    assign rbank = ~wbank;

    // bank select and opaque flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbank      <= 1'b0;
            opq        <= '0;  // both banks start empty
            obj_opaque <= 1'b0;
        end else begin
            if (line_start) begin
                wbank <= ~wbank;  // last written bank becomes the read bank
            end
            if (buf_we) begin
                opq[wbank][buf_waddr] <= 1'b1;  // any write is opaque
            end
            if (scan_en) begin
                obj_opaque <= opq[rbank][hdump];
                opq[rbank][hdump] <= 1'b0;  // clear so next line starts empty
            end
        end
    end

    // color storage, only meaningful where the flag is set
    always_ff @(posedge clk) begin
        if (buf_we) begin
            col_ram[wbank][buf_waddr] <= buf_wdata;
        end
        if (scan_en) begin
            obj_color <= col_ram[rbank][hdump];
        end
    end

endmodule

//--- line_video_top.f
design/line_video_pkg.sv
design/obj_draw.sv
design/obj_line_buffer.sv
design/char_draw.sv
design/layer_mix.sv
design/line_video_top.sv
sim/line_video_checker.sv
sim/line_video_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it, exit status gives pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --x-initial 0 \
    --top-module line_video_tb -f line_video_top.f -o line_video_sim &&
./obj_dir/line_video_sim || { echo "simulation failed"; exit 1; }

//--- sim/line_video_checker.sv
// concurrent checks on object intake, rom request and buffer writes of the object drawer
module line_video_checker
    import line_video_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input obj_state_e        state,
    input logic              obj_ready,
    input logic              rom_req,
    input logic              rom_ack,
    input logic [ROM_AW-1:0] rom_addr,
    input logic              buf_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // intake only while idle
    ready_idle: assert property (@(posedge clk) disable iff (rst)
        (state != OBJ_IDLE) |-> !obj_ready) else $error("obj_ready high outside OBJ_IDLE");

    // address held until the ack
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (rom_req && !rom_ack) |=> $stable(rom_addr)) else $error("rom_addr moved during request");

    write_in_draw: assert property (@(posedge clk) disable iff (rst)
        buf_we |-> (state == OBJ_DRAW)) else $error("buf_we high outside OBJ_DRAW");

endmodule

//--- sim/line_video_tb.sv
// testbench: clock, reset, rom model, table loading, object and scan stimulus, reference model, compare
module line_video_tb
    import line_video_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYC = 20000;  // 6 lines x (256 + 12 objects x 25) x 2, rounded up

    logic               clk;
    logic               rst;
    logic               obj_valid, obj_ready, obj_hflip, obj_vflip;
    logic [7:0]         obj_xpos, obj_code, hdump;
    logic [3:0]         obj_row, obj_pal;
    logic               rom_req, rom_ack, prog_en, line_start, scan_en, pix_valid;
    logic [ROM_AW-1:0]  rom_addr;
    logic [31:0]        rom_data;
    prog_target_e       prog_sel;
    logic [PROG_AW-1:0] prog_addr;
    logic [PROG_DW-1:0] prog_data;
    logic [2:0]         char_row;
    logic [COLOR_W-1:0] pix_color;
    int                 cyc = 0;

    // reference copies of the tables and both buffer banks
    logic [COLOR_W-1:0] pal_m [64];
    logic [7:0]         map_m [32];
    logic [PROG_DW-1:0] pat_m [128];
    logic               opq_m [2][LINE_W];
    logic [COLOR_W-1:0] col_m [2][LINE_W];
    logic               wsel = 1'b0;  // bank being drawn into
    logic [COLOR_W-1:0] exp_col_q [$];
    int                 exp_cyc_q [$];  // cycle each pixel is due

    line_video_top u_line_video_top (.*);

    bind obj_draw line_video_checker u_line_video_checker (
        .clk(clk), .rst(rst), .state(state), .obj_ready(obj_ready), .rom_req(rom_req),
        .rom_ack(rom_ack), .rom_addr(rom_addr), .buf_we(buf_we)
    );

    // fixed hash standing in for the pattern rom
    function automatic logic [31:0] rom_word(input logic [ROM_AW-1:0] a);
        logic [31:0] h;
        h = {20'h0, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        return h ^ (h >> 13);
    endfunction

    // opaque object pixel over the character pixel
    function automatic logic [COLOR_W-1:0] ref_pixel(input logic [7:0] h, input logic [2:0] row);
        logic [7:0]  ent;
        logic [15:0] prow;
        logic [1:0]  idx;
        if (opq_m[~wsel][h]) return col_m[~wsel][h];
        ent  = map_m[h[7:3]];  // code in 7..4, cpal in 3..0
        prow = pat_m[{ent[7:4], row}];
        idx  = prow[2*h[2:0] +: 2];
        return {ent[1:0], idx};
    endfunction

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // one object into the write bank, later writes win
    task automatic draw_model(input logic [7:0] x, input logic [3:0] row, input logic [7:0] code,
                              input logic [3:0] pal, input logic hf, input logic vf);
        logic [31:0] w;
        logic [1:0]  idx;
        logic [7:0]  a;
        w = rom_word({code, row ^ {4{vf}}});
        for (int i = 0; i < OBJ_W; i++) begin
            idx = {w[16+i], w[i]};  // plane B then plane A
            a   = hf ? (x + 8'd15 - 8'(i)) : (x + 8'(i));  // wraps mod 256
            if (idx != 2'd0) begin
                opq_m[wsel][a] = 1'b1;
                col_m[wsel][a] = pal_m[{pal, idx}];
            end
        end
    endtask

    task automatic prog_write(input prog_target_e sel, input logic [6:0] a, input logic [15:0] d);
        prog_en   = 1'b1;
        prog_sel  = sel;
        prog_addr = a;
        prog_data = d;
        @(posedge clk);
        #2 prog_en = 1'b0;
    endtask

    task automatic load_tables();
        logic [15:0] d;
        for (int i = 0; i < 64; i++) begin
            d = 16'($urandom());
            pal_m[i] = d[3:0];
            prog_write(PROG_OBJ_PAL, 7'(i), d);
        end
        for (int i = 0; i < 32; i++) begin
            d = 16'($urandom());
            map_m[i] = d[7:0];
            prog_write(PROG_CHAR_MAP, 7'(i), d);
        end
        for (int i = 0; i < 128; i++) begin
            d = 16'($urandom());
            pat_m[i] = d;
            prog_write(PROG_CHAR_PAT, 7'(i), d);
        end
    endtask

    // random descriptor at x, returns once obj_ready is back
    task automatic send_obj(input logic [7:0] x);
        logic [31:0] r;
        r = $urandom();
        while (!obj_ready) begin
            @(posedge clk);
            #2;
        end
        obj_valid = 1'b1;
        obj_xpos  = x;
        {obj_row, obj_code, obj_pal, obj_hflip, obj_vflip} = r[17:0];
        draw_model(x, r[17:14], r[13:6], r[5:2], r[1], r[0]);
        @(posedge clk);  // accepted here
        #2 obj_valid = 1'b0;
        while (!obj_ready) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic draw_objs(input int n, input logic [7:0] base, input int spread);
        for (int k = 0; k < n; k++) send_obj(base + 8'($urandom() % spread));
    endtask

    task automatic line_swap();
        line_start = 1'b1;
        wsel       = ~wsel;
        @(posedge clk);
        #2 line_start = 1'b0;
    endtask

    // full line, one pixel per cycle, then wait for the pipeline to empty
    task automatic scan_line(input logic [2:0] row);
        for (int h = 0; h < LINE_W; h++) begin
            scan_en  = 1'b1;
            hdump    = 8'(h);
            char_row = row;
            exp_col_q.push_back(ref_pixel(8'(h), row));
            exp_cyc_q.push_back(cyc + SCAN_LAT);
            opq_m[~wsel][h] = 1'b0;  // read clears
            @(posedge clk);
            #2;
        end
        scan_en = 1'b0;
        while (exp_col_q.size() > 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle count and run limit
    initial begin
        forever begin
            @(posedge clk);
            cyc++;
            if (cyc >= TIMEOUT_CYC) begin
                $display("timeout, run still going after %0d cycles", cyc);
                stop_failed();
            end
        end
    end

    // rom model, ack 1 to 6 cycles after the request
    initial begin
        int dly;
        rom_ack  = 1'b0;
        rom_data = '0;
        forever begin
            @(posedge clk);
            #2 rom_ack = 1'b0;
            if (rom_req) begin
                dly = int'($urandom() % 6) + 1;
                repeat (dly - 1) begin
                    @(posedge clk);
                    #2;
                end
                rom_data = rom_word(rom_addr);
                rom_ack  = 1'b1;
            end
        end
    end

    // compare, sampled at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (pix_valid || (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cyc)) begin
                assert (pix_valid && exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc) else begin
                    $display("pix_valid not %0d cycles after its scan_en at %0t", SCAN_LAT, $time);
                    stop_failed();
                end
                assert (pix_color == exp_col_q[0]) else begin
                    $display("Mismatch at %0t: pix_color got %h expected %h",
                             $time, pix_color, exp_col_q[0]);
                    stop_failed();
                end
                void'(exp_col_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(32'hc8c2_5e4f));
        rst        = 1'b1;
        obj_valid  = 1'b0;
        {obj_xpos, obj_row, obj_code, obj_pal, obj_hflip, obj_vflip} = '0;
        prog_en    = 1'b0;
        prog_sel   = PROG_OBJ_PAL;
        prog_addr  = '0;
        prog_data  = '0;
        line_start = 1'b0;
        scan_en    = 1'b0;
        hdump      = '0;
        char_row   = '0;
        for (int i = 0; i < LINE_W; i++) begin
            {opq_m[0][i], opq_m[1][i], col_m[0][i], col_m[1][i]} = '0;
            if (i < 64) pal_m[i] = '0;
            if (i < 32) map_m[i] = '0;
            if (i < 128) pat_m[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        assert (!pix_valid && !rom_req && obj_ready) else begin
            $display("outputs not at their reset values after reset");
            stop_failed();
        end
        scan_line(3'd0);  // empty tables, color 0
        load_tables();
        scan_line(3'd3);  // characters only
        send_obj(8'd247);  // runs past x 255
        draw_objs(11, 8'd0, 256);
        line_swap();
        scan_line(3'd5);
        draw_objs(8, 8'd96, 6);  // heavy overlap
        line_swap();
        scan_line(3'd1);
        scan_line(3'd1);  // same bank again, already cleared
        draw_objs(12, 8'd0, 256);
        line_swap();
        fork
            scan_line(3'd6);
            draw_objs(12, 8'd0, 256);  // next line built during this scan
        join
        line_swap();
        scan_line(3'd7);
        $display("TEST PASSED");
        $finish;
    end

endmodule
